//--- verilog/est_rx_settings.svh
`ifndef EST_RX_SETTINGS_SVH
`define EST_RX_SETTINGS_SVH

// flow id width and the number of flows it can address.
`define EST_RX_FLOWID_W     3
`define EST_RX_NUM_FLOWS    (1 << `EST_RX_FLOWID_W)

// sequence and ack numbers.
`define EST_RX_SEQ_W        32

// receive buffer is 2**BUF_PTR_W bytes per flow.
`define EST_RX_BUF_PTR_W    6
`define EST_RX_BUF_SIZE     (1 << `EST_RX_BUF_PTR_W)

`define EST_RX_LEN_W        7

`endif

//--- verilog/est_rx_pkg.sv
`include "est_rx_settings.svh"

package est_rx_pkg;

    typedef logic [`EST_RX_FLOWID_W-1:0]  flowid_t;

    typedef logic [`EST_RX_SEQ_W-1:0]     seq_num_t;  // wraps.

    // one extra bit so a full buffer differs from an empty one.
    typedef logic [`EST_RX_BUF_PTR_W:0]   buf_ptr_t;

    typedef logic [`EST_RX_LEN_W-1:0]     payload_len_t;  // bytes.

endpackage

//--- verilog/flow_state_table.sv
`include "est_rx_settings.svh"

module flow_state_table (
     input                              clk
    ,input                              rst

    ,input  est_rx_pkg::flowid_t        rd_flowid
    ,output est_rx_pkg::seq_num_t       rd_ack_num
    ,output est_rx_pkg::buf_ptr_t       rd_tail_ptr
    ,output est_rx_pkg::buf_ptr_t       rd_head_ptr

    ,input                              wr_en
    ,input  est_rx_pkg::flowid_t        wr_flowid
    ,input  est_rx_pkg::seq_num_t       wr_ack_num
    ,input  est_rx_pkg::buf_ptr_t       wr_tail_ptr

    ,input                              consume_valid
    ,input  est_rx_pkg::flowid_t        consume_flowid
    ,input  est_rx_pkg::payload_len_t   consume_len
);

    est_rx_pkg::seq_num_t   ack_num_r  [`EST_RX_NUM_FLOWS];
    est_rx_pkg::buf_ptr_t   tail_ptr_r [`EST_RX_NUM_FLOWS];
    est_rx_pkg::buf_ptr_t   head_ptr_r [`EST_RX_NUM_FLOWS];

    est_rx_pkg::buf_ptr_t   consume_head_next;

    // reads are combinational since the pipe registers the flow id.
    assign rd_ack_num  = ack_num_r[rd_flowid];
    assign rd_tail_ptr = tail_ptr_r[rd_flowid];
    assign rd_head_ptr = head_ptr_r[rd_flowid];

    // the writeback stage owns the ack number and tail pointer.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EST_RX_NUM_FLOWS; i++) begin
                ack_num_r[i]  <= '0;
                tail_ptr_r[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                ack_num_r[wr_flowid]  <= wr_ack_num;
                tail_ptr_r[wr_flowid] <= wr_tail_ptr;
            end
        end
    end

    // the application frees buffer space by moving the head.
    assign consume_head_next = head_ptr_r[consume_flowid] + consume_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EST_RX_NUM_FLOWS; i++) begin
                head_ptr_r[i] <= '0;
            end
        end else begin
            if (consume_valid) begin
                head_ptr_r[consume_flowid] <= consume_head_next;
            end
        end
    end

endmodule

//--- verilog/rx_accept_logic.sv
`include "est_rx_settings.svh"

module rx_accept_logic (
    // compute stage packet.
     input                              c_valid
    ,input  est_rx_pkg::flowid_t        c_flowid
    ,input  est_rx_pkg::seq_num_t       c_seq_num
    ,input  est_rx_pkg::payload_len_t   c_len

    // table read data for c_flowid.
    ,input  est_rx_pkg::seq_num_t       tbl_ack_num
    ,input  est_rx_pkg::buf_ptr_t       tbl_tail_ptr
    ,input  est_rx_pkg::buf_ptr_t       tbl_head_ptr

    // writeback contents not yet in the table.
    ,input                              w_valid
    ,input  est_rx_pkg::flowid_t        w_flowid
    ,input  est_rx_pkg::seq_num_t       w_ack_num
    ,input  est_rx_pkg::buf_ptr_t       w_tail_ptr

    ,output logic                       accept
    ,output est_rx_pkg::seq_num_t       next_ack_num
    ,output est_rx_pkg::buf_ptr_t       next_tail_ptr
    ,output est_rx_pkg::buf_ptr_t       prev_tail_ptr
    ,output est_rx_pkg::buf_ptr_t       space_left
);

    logic                   byp_state;
    est_rx_pkg::seq_num_t   curr_ack_num;
    est_rx_pkg::buf_ptr_t   curr_tail_ptr;
    est_rx_pkg::buf_ptr_t   space_used;

    logic                   len_nonzero;
    logic                   in_order;
    logic                   has_space;

    // writeback holds newer state for the same flow.
    assign byp_state = c_valid & w_valid & (c_flowid == w_flowid);

    assign curr_ack_num  = byp_state ? w_ack_num  : tbl_ack_num;
    assign curr_tail_ptr = byp_state ? w_tail_ptr : tbl_tail_ptr;

    // the wrap bit keeps the difference correct across a pointer wrap.
    assign space_used = curr_tail_ptr - tbl_head_ptr;
    assign space_left = est_rx_pkg::buf_ptr_t'(`EST_RX_BUF_SIZE) - space_used;

    assign len_nonzero = (c_len != '0);
    assign in_order    = (c_seq_num == curr_ack_num);
    assign has_space   = (space_left >= c_len);

    assign accept = c_valid & len_nonzero & in_order & has_space;

    // payload lands at the old tail.
    assign prev_tail_ptr = curr_tail_ptr;

    assign next_tail_ptr = accept ? curr_tail_ptr + c_len : curr_tail_ptr;

    assign next_ack_num = accept
                        ? curr_ack_num + est_rx_pkg::seq_num_t'(c_len)
                        : curr_ack_num;  // a rejected packet leaves the ack alone.

endmodule

//--- verilog/est_rx_pipe.sv
module est_rx_pipe (
     input                              clk
    ,input                              rst

    ,input                              in_valid
    ,output logic                       in_ready
    ,input  est_rx_pkg::flowid_t        in_flowid
    ,input  est_rx_pkg::seq_num_t       in_seq_num
    ,input  est_rx_pkg::payload_len_t   in_payload_len

    ,input                              consume_valid
    ,input  est_rx_pkg::flowid_t        consume_flowid
    ,input  est_rx_pkg::payload_len_t   consume_len

    ,output logic                       result_valid
    ,input                              result_ready
    ,output est_rx_pkg::flowid_t        result_flowid
    ,output logic                       result_accept
    ,output est_rx_pkg::buf_ptr_t       result_buf_ptr
    ,output est_rx_pkg::payload_len_t   result_len
    ,output est_rx_pkg::seq_num_t       result_ack_num
    ,output est_rx_pkg::buf_ptr_t       result_wnd
);

    logic                       stall_c;
    logic                       stall_w;

    // compute stage register.
    logic                       c_valid_r;
    est_rx_pkg::flowid_t        c_flowid_r;
    est_rx_pkg::seq_num_t       c_seq_num_r;
    est_rx_pkg::payload_len_t   c_len_r;

    // table read data for the compute flow.
    est_rx_pkg::seq_num_t       tbl_ack_num;
    est_rx_pkg::buf_ptr_t       tbl_tail_ptr;
    est_rx_pkg::buf_ptr_t       tbl_head_ptr;

    // compute stage results.
    logic                       accept_c;
    est_rx_pkg::seq_num_t       next_ack_num_c;
    est_rx_pkg::buf_ptr_t       next_tail_ptr_c;
    est_rx_pkg::buf_ptr_t       prev_tail_ptr_c;
    est_rx_pkg::buf_ptr_t       space_left_c;

    // writeback stage register.
    logic                       w_valid_r;
    est_rx_pkg::flowid_t        w_flowid_r;
    logic                       w_accept_r;
    est_rx_pkg::payload_len_t   w_len_r;
    est_rx_pkg::seq_num_t       w_ack_num_r;
    est_rx_pkg::buf_ptr_t       w_tail_ptr_r;
    est_rx_pkg::buf_ptr_t       w_prev_tail_ptr_r;
    est_rx_pkg::buf_ptr_t       w_wnd_r;

    logic                       result_fire;

    assign result_fire = w_valid_r & result_ready;

    // stalls start at the result port and move backwards.
    assign stall_w  = w_valid_r & ~result_ready;
    assign stall_c  = c_valid_r & stall_w;
    assign in_ready = ~stall_c;

    always_ff @(posedge clk) begin
        if (rst) begin
            c_valid_r <= 1'b0;
        end else begin
            if (~stall_c) begin
                c_valid_r <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_c) begin
            c_flowid_r  <= in_flowid;
            c_seq_num_r <= in_seq_num;
            c_len_r     <= in_payload_len;
        end
    end

    flow_state_table state_table (
         .clk               (clk            )
        ,.rst               (rst            )

        ,.rd_flowid         (c_flowid_r     )
        ,.rd_ack_num        (tbl_ack_num    )
        ,.rd_tail_ptr       (tbl_tail_ptr   )
        ,.rd_head_ptr       (tbl_head_ptr   )

        ,.wr_en             (result_fire    )  // state commits with the result.
        ,.wr_flowid         (w_flowid_r     )
        ,.wr_ack_num        (w_ack_num_r    )
        ,.wr_tail_ptr       (w_tail_ptr_r   )

        ,.consume_valid     (consume_valid  )
        ,.consume_flowid    (consume_flowid )
        ,.consume_len       (consume_len    )
    );

    rx_accept_logic accept_logic (
         .c_valid           (c_valid_r      )
        ,.c_flowid          (c_flowid_r     )
        ,.c_seq_num         (c_seq_num_r    )
        ,.c_len             (c_len_r        )

        ,.tbl_ack_num       (tbl_ack_num    )
        ,.tbl_tail_ptr      (tbl_tail_ptr   )
        ,.tbl_head_ptr      (tbl_head_ptr   )

        ,.w_valid           (w_valid_r      )
        ,.w_flowid          (w_flowid_r     )
        ,.w_ack_num         (w_ack_num_r    )
        ,.w_tail_ptr        (w_tail_ptr_r   )

        ,.accept            (accept_c       )
        ,.next_ack_num      (next_ack_num_c )
        ,.next_tail_ptr     (next_tail_ptr_c)
        ,.prev_tail_ptr     (prev_tail_ptr_c)
        ,.space_left        (space_left_c   )
    );

    // a bubble moves into writeback whenever compute is empty.
    always_ff @(posedge clk) begin
        if (rst) begin
            w_valid_r <= 1'b0;
        end else begin
            if (~stall_w) begin
                w_valid_r <= c_valid_r;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_w) begin
            w_flowid_r        <= c_flowid_r;
            w_accept_r        <= accept_c;
            w_len_r           <= c_len_r;
            w_ack_num_r       <= next_ack_num_c;
            w_tail_ptr_r      <= next_tail_ptr_c;
            w_prev_tail_ptr_r <= prev_tail_ptr_c;
            w_wnd_r           <= space_left_c;  // window seen before this payload.
        end
    end

    assign result_valid   = w_valid_r;
    assign result_flowid  = w_flowid_r;
    assign result_accept  = w_accept_r;
    assign result_buf_ptr = w_prev_tail_ptr_r;
    assign result_len     = w_len_r;
    assign result_ack_num = w_ack_num_r;
    assign result_wnd     = w_wnd_r;

endmodule

//--- dv/est_rx_pipe_tb.sv
`include "est_rx_settings.svh"

module est_rx_pipe_tb;

    typedef struct packed {
        est_rx_pkg::flowid_t        flowid;
        logic                       accept;
        est_rx_pkg::buf_ptr_t       buf_ptr;
        est_rx_pkg::payload_len_t   len;
        est_rx_pkg::seq_num_t       ack;
        est_rx_pkg::buf_ptr_t       wnd;
    } exp_result_t;

    localparam int WAIT_LIMIT = 400;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    est_rx_pkg::flowid_t        in_flowid;
    est_rx_pkg::seq_num_t       in_seq_num;
    est_rx_pkg::payload_len_t   in_payload_len;
    logic                       consume_valid;
    est_rx_pkg::flowid_t        consume_flowid;
    est_rx_pkg::payload_len_t   consume_len;
    logic                       result_valid;
    logic                       result_ready;
    est_rx_pkg::flowid_t        result_flowid;
    logic                       result_accept;
    est_rx_pkg::buf_ptr_t       result_buf_ptr;
    est_rx_pkg::payload_len_t   result_len;
    est_rx_pkg::seq_num_t       result_ack_num;
    est_rx_pkg::buf_ptr_t       result_wnd;

    // reference model state with one entry per flow.
    est_rx_pkg::seq_num_t       model_ack  [`EST_RX_NUM_FLOWS];
    est_rx_pkg::buf_ptr_t       model_tail [`EST_RX_NUM_FLOWS];
    est_rx_pkg::buf_ptr_t       model_head [`EST_RX_NUM_FLOWS];

    exp_result_t                exp_q[$];
    exp_result_t                exp_head;
    logic                       exp_valid = 1'b0;
    exp_result_t                last_res;  // last result seen on the port.

    int                         packets_sent = 0;
    int                         errors = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    logic                       ready_random = 1'b0;

    est_rx_pipe UUT (
         .clk               (clk            )
        ,.rst               (rst            )
        ,.in_valid          (in_valid       )
        ,.in_ready          (in_ready       )
        ,.in_flowid         (in_flowid      )
        ,.in_seq_num        (in_seq_num     )
        ,.in_payload_len    (in_payload_len )
        ,.consume_valid     (consume_valid  )
        ,.consume_flowid    (consume_flowid )
        ,.consume_len       (consume_len    )
        ,.result_valid      (result_valid   )
        ,.result_ready      (result_ready   )
        ,.result_flowid     (result_flowid  )
        ,.result_accept     (result_accept  )
        ,.result_buf_ptr    (result_buf_ptr )
        ,.result_len        (result_len     )
        ,.result_ack_num    (result_ack_num )
        ,.result_wnd        (result_wnd     )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // accept rule applied to the model in input order.
    function automatic exp_result_t predict(input est_rx_pkg::flowid_t f,
                                            input est_rx_pkg::seq_num_t s,
                                            input est_rx_pkg::payload_len_t l);
        exp_result_t r;
        est_rx_pkg::buf_ptr_t used;
        used = model_tail[f] - model_head[f];
        r.flowid = f;
        r.len = l;
        r.buf_ptr = model_tail[f];
        r.wnd = est_rx_pkg::buf_ptr_t'(`EST_RX_BUF_SIZE) - used;
        r.accept = (l != 0) && (s == model_ack[f]) && (l <= r.wnd);
        if (r.accept) begin
            model_ack[f] = model_ack[f] + l;
            model_tail[f] = model_tail[f] + l;
        end
        r.ack = model_ack[f];
        return r;
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            if (result_valid && result_ready) begin
                last_res = {result_flowid, result_accept, result_buf_ptr, result_len,
                            result_ack_num, result_wnd};
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(predict(in_flowid, in_seq_num, in_payload_len));
                packets_sent++;
            end
            exp_valid = (exp_q.size() > 0);
            if (exp_valid) begin
                exp_head = exp_q[0];
            end
        end
    end

    no_spurious_result: assert property (@(posedge clk) disable iff (rst)
        (result_valid && result_ready) |-> exp_valid)
        else begin
            errors++;
            $display("a result came out at %0t with no packet outstanding", $time);
        end

    result_matches: assert property (@(posedge clk) disable iff (rst)
        (result_valid && result_ready && exp_valid) |->
            (result_flowid == exp_head.flowid && result_accept == exp_head.accept
             && result_buf_ptr == exp_head.buf_ptr && result_len == exp_head.len
             && result_ack_num == exp_head.ack && result_wnd == exp_head.wnd))
        else begin
            errors++;
            $display("MISMATCH at %0t: flow %0d got accept %0b ptr %0d ack %0d wnd %0d, ",
                     $time, $sampled(result_flowid), $sampled(result_accept),
                     $sampled(result_buf_ptr), $sampled(result_ack_num), $sampled(result_wnd),
                     "expected accept %0b ptr %0d ack %0d wnd %0d",
                     $sampled(exp_head.accept), $sampled(exp_head.buf_ptr),
                     $sampled(exp_head.ack), $sampled(exp_head.wnd));
        end

    // result port back-pressure.
    initial begin
        forever begin
            @(negedge clk);
            if (ready_random) begin
                result_ready = ($urandom_range(0, 2) != 0);
            end else begin
                result_ready = 1'b1;
            end
        end
    end

    // called on a falling edge and returns on the falling edge after the transfer.
    task automatic send_packet(input est_rx_pkg::flowid_t f, input est_rx_pkg::seq_num_t s,
                               input est_rx_pkg::payload_len_t l);
        int target;
        int waited;
        target = packets_sent + 1;
        waited = 0;
        in_valid = 1'b1;
        in_flowid = f;
        in_seq_num = s;
        in_payload_len = l;
        while (packets_sent < target) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout at %0t: the DUT never took a packet on flow %0d", $time, f);
                $display("Something failed");
                $finish;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout at %0t: %0d results never came out", $time, exp_q.size());
                $display("Something failed");
                $finish;
            end
        end
    endtask

    task automatic consume_bytes(input est_rx_pkg::flowid_t f,
                                 input est_rx_pkg::payload_len_t n);
        consume_valid = 1'b1;
        consume_flowid = f;
        consume_len = n;
        model_head[f] = model_head[f] + n;  // nothing is in flight so it applies now.
        @(negedge clk);
        consume_valid = 1'b0;
    endtask

    task automatic check_last(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("MISMATCH at %0t: %s (accept %0b ptr %0d ack %0d wnd %0d)", $time, what,
                     last_res.accept, last_res.buf_ptr, last_res.ack, last_res.wnd);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e;
        est_rx_pkg::flowid_t f;
        est_rx_pkg::seq_num_t s;
        void'($urandom(32'ha505a7f2));
        rst = 1'b1;
        in_valid = 1'b0;
        in_flowid = '0;
        in_seq_num = '0;
        in_payload_len = '0;
        consume_valid = 1'b0;
        consume_flowid = '0;
        consume_len = '0;
        result_ready = 1'b1;
        for (int i = 0; i < `EST_RX_NUM_FLOWS; i++) begin
            model_ack[i] = '0;
            model_tail[i] = '0;
            model_head[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e = errors;
        assert (!result_valid && in_ready) else begin
            errors++;
            $display("MISMATCH at %0t: result_valid %0b in_ready %0b after reset", $time,
                     result_valid, in_ready);
        end
        send_packet(0, 0, 10);
        wait_idle();
        check_last(last_res.accept && last_res.buf_ptr == 0 && last_res.ack == 10,
                   "first packet not accepted at pointer 0");
        report_test("reset_and_first", e);

        e = errors;
        send_packet(0, model_ack[0], 5);  // back to back so the bypass is used.
        send_packet(0, model_ack[0], 7);
        send_packet(0, model_ack[0], 3);
        send_packet(0, model_ack[0], 9);
        send_packet(0, model_ack[0], 6);
        wait_idle();
        check_last(last_res.accept && last_res.ack == 40 && last_res.buf_ptr == 34,
                   "back-to-back packets did not advance the state");
        report_test("back_to_back", e);

        e = errors;
        send_packet(1, 100, 8);
        wait_idle();
        check_last(!last_res.accept && last_res.ack == 0, "out-of-order packet accepted");
        send_packet(1, 0, 0);
        wait_idle();
        check_last(!last_res.accept && last_res.ack == 0, "empty packet accepted");
        send_packet(1, 0, 8);
        wait_idle();
        check_last(last_res.accept && last_res.buf_ptr == 0, "state moved on a rejected packet");
        report_test("reject", e);

        e = errors;
        send_packet(2, model_ack[2], 30);
        send_packet(2, model_ack[2], 30);
        send_packet(2, model_ack[2], 4);
        send_packet(2, model_ack[2], 10);
        wait_idle();
        check_last(!last_res.accept && last_res.wnd < 10, "packet accepted into a full buffer");
        consume_bytes(2, 20);
        send_packet(2, model_ack[2], 10);
        wait_idle();
        check_last(last_res.accept && last_res.buf_ptr == 64, "packet rejected after consume");
        report_test("buffer_full", e);

        e = errors;
        ready_random = 1'b1;
        for (int batch = 0; batch < 4; batch++) begin
            for (int n = 0; n < 25; n++) begin
                f = $urandom_range(0, `EST_RX_NUM_FLOWS - 1);
                s = model_ack[f];
                if ($urandom_range(0, 5) == 0) begin
                    s = s + 1;  // occasional out-of-order segment.
                end
                send_packet(f, s, $urandom_range(0, 40));
            end
            wait_idle();
            for (int i = 0; i < `EST_RX_NUM_FLOWS; i++) begin
                if (model_tail[i] != model_head[i]) begin
                    consume_bytes(i, model_tail[i] - model_head[i]);
                end
            end
        end
        ready_random = 1'b0;
        wait_idle();
        report_test("random_traffic", e);

        $display("%0d tests passed, %0d failed, %0d errors, %0d packets",
                 tests_passed, tests_failed, errors, packets_sent);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- est_rx.f
+incdir+verilog
verilog/est_rx_pkg.sv
verilog/flow_state_table.sv
verilog/rx_accept_logic.sv
verilog/est_rx_pipe.sv
dv/est_rx_pipe_tb.sv
